// File: build.f
rtl/apg_pkg.sv
rtl/apg_regs.sv
rtl/apg_pattern_mem.sv
rtl/apg_trigger_sync.sv
rtl/apg_wave_engine.sv
rtl/apg_top.sv
verification/apg_checker.sv
verification/apg_tb.sv

// File: rtl/apg_pattern_mem.sv
// Pattern and capture buffers of the pattern generator
// Host side writes patterns and pops captures on axi_clk
// Wave engine reads patterns and writes captures on wave_clk
// Buffers are only touched from one side at a time, so no FIFO is needed

`timescale 1ns/1ps

module apg_pattern_mem #(
   parameter int NUM_SIG  = 14,
   parameter int NUM_SAMP = 128
) (
   input  logic               axi_clk,
   input  logic               axi_resetn,
   input  logic               wave_clk,
   input  logic               push,
   input  logic [NUM_SIG-1:0] push_data,
   input  logic               pop,
   output logic [NUM_SIG-1:0] pop_data,
   output logic [31:0]        write_len,
   output logic [31:0]        read_ptr,
   input  logic               shot_done,
   input  logic [31:0]        rd_index,
   output logic [NUM_SIG-1:0] rd_word,
   input  logic               cap_en,
   input  logic [31:0]        cap_index,
   input  logic [NUM_SIG-1:0] cap_word
);

   // Word address width of both buffers
   localparam int IDX_W = (NUM_SAMP > 1) ? $clog2(NUM_SAMP) : 1;

   logic [NUM_SIG-1:0] pat_mem [NUM_SAMP];
   logic [NUM_SIG-1:0] cap_mem [NUM_SAMP];

   logic             full;
   logic             push_ok;
   logic             ptr_end;
   logic [IDX_W-1:0] wr_addr;
   logic [IDX_W-1:0] pop_addr;

   // Pattern buffer fill state
   assign full    = (write_len >= NUM_SAMP);
   assign push_ok = push & ~full;
   assign wr_addr = write_len[IDX_W-1:0];

   // Pop pointer saturates at NUM_SAMP
   // past the end the last capture word is returned again
   assign ptr_end  = (read_ptr >= NUM_SAMP);
   assign pop_addr = ptr_end ? IDX_W'(NUM_SAMP - 1) : read_ptr[IDX_W-1:0];

   // Host pointers
   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         write_len <= '0;
         read_ptr  <= '0;
      end else if (shot_done) begin
         // New shot results ready, pattern may be refilled
         write_len <= '0;
         read_ptr  <= '0;
      end else begin
         // Pushes into a full buffer are dropped
         if (push_ok)
            write_len <= write_len + 32'd1;
         if (pop && !ptr_end)
            read_ptr <= read_ptr + 32'd1;
      end
   end

   // Pattern write port, axi_clk
   always_ff @(posedge axi_clk) begin
      if (push_ok)
         pat_mem[wr_addr] <= push_data;
   end

   // Capture read port, registered on the pop edge
   always_ff @(posedge axi_clk) begin
      if (pop)
         pop_data <= cap_mem[pop_addr];
   end

   // Pattern read port for the engine
   // Asynchronous, the engine registers the word onto the pins
   assign rd_word = pat_mem[rd_index[IDX_W-1:0]];

   // Capture write port, wave_clk
   always_ff @(posedge wave_clk) begin
      if (cap_en)
         cap_mem[cap_index[IDX_W-1:0]] <= cap_word;
   end

endmodule

// File: rtl/apg_pkg.sv
// Shared definitions for the arbitrary pattern generator
// Register map, engine states, host bus structs and the status word
// Modules refer to these by scoped names

package apg_pkg;

   // Register word addresses on the host bus
   typedef enum logic [3:0] {
      CTRL          = 4'd0,
      N_SAMPLES     = 4'd1,
      WRITE_CHANNEL = 4'd2,
      READ_CHANNEL  = 4'd3,
      SAMPLE_COUNT  = 4'd4,
      WRITE_LEN     = 4'd5,
      READ_PTR      = 4'd6,
      STATUS        = 4'd7
   } reg_addr_e;

   // Wave engine FSM states
   typedef enum logic [1:0] {
      IDLE        = 2'd0,
      TRANSACTION = 2'd1,
      DONE        = 2'd2
   } engine_state_e;

   // Host request, valid for a single axi_clk cycle
   typedef struct packed {
      logic       valid;
      logic       write;
      reg_addr_e  addr;
      logic [31:0] wdata;
   } reg_req_t;

   // Response, one cycle after the request
   typedef struct packed {
      logic       valid;
      logic [31:0] rdata;
   } reg_rsp_t;

   // Status word, 4 bits, read through STATUS
   typedef struct packed {
      logic          busy;
      logic          triggered;
      engine_state_e state;
   } apg_status_t;

   // CTRL word bit positions
   localparam int CTRL_RUN_BIT  = 0;
   localparam int CTRL_LOOP_BIT = 1;
   localparam int CTRL_STOP_BIT = 2;

endpackage

// File: rtl/apg_regs.sv
// Host register block of the pattern generator, axi_clk domain
// Decodes one-cycle requests and returns a registered response next cycle
// Holds shot length and loop bit, makes push/pop strobes and run/stop pulses

`timescale 1ns/1ps

module apg_regs #(
   parameter int NUM_SIG  = 14,
   parameter int NUM_SAMP = 128
) (
   input  logic                 axi_clk,
   input  logic                 axi_resetn,
   input  apg_pkg::reg_req_t    req,
   output apg_pkg::reg_rsp_t    rsp,
   input  logic                 busy,
   input  apg_pkg::apg_status_t status,
   output logic                 push,
   output logic [NUM_SIG-1:0]   push_data,
   output logic                 pop,
   input  logic [NUM_SIG-1:0]   pop_data,
   input  logic [31:0]          write_len,
   input  logic [31:0]          read_ptr,
   input  logic [31:0]          sample_count,
   output logic [31:0]          n_samples_eff,
   output logic                 loop,
   output logic                 run_pulse,
   output logic                 stop_pulse
);

   logic        wr_en;
   logic        rd_en;
   logic        ctrl_wr;
   logic        nsamp_wr;
   logic        chan_rd;
   logic [31:0] rdata_d;
   logic [31:0] rdata_q;
   logic [31:0] chan_word;
   logic        rsp_valid_q;
   logic        chan_rd_q;

   // Access qualifiers
   assign wr_en    = req.valid & req.write;
   assign rd_en    = req.valid & ~req.write;
   assign ctrl_wr  = wr_en & (req.addr == apg_pkg::CTRL);
   assign nsamp_wr = wr_en & (req.addr == apg_pkg::N_SAMPLES);
   assign chan_rd  = rd_en & (req.addr == apg_pkg::READ_CHANNEL);

   // Buffer strobes, dropped while a shot owns the buffers
   assign push      = wr_en & (req.addr == apg_pkg::WRITE_CHANNEL) & ~busy;
   assign push_data = req.wdata[NUM_SIG-1:0];
   assign pop       = chan_rd & ~busy;

   // Read mux for everything except the capture channel
   always_comb begin
      rdata_d = '0;
      case (req.addr)
         apg_pkg::CTRL:         rdata_d[apg_pkg::CTRL_LOOP_BIT] = loop;
         apg_pkg::N_SAMPLES:    rdata_d = n_samples_eff;
         apg_pkg::SAMPLE_COUNT: rdata_d = sample_count;
         apg_pkg::WRITE_LEN:    rdata_d = write_len;
         apg_pkg::READ_PTR:     rdata_d = read_ptr;
         apg_pkg::STATUS:       rdata_d[$bits(apg_pkg::apg_status_t)-1:0] = status;
         default:               rdata_d = '0;
      endcase
   end

   // Control state and response handshake
   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         rsp_valid_q   <= 1'b0;
         chan_rd_q     <= 1'b0;
         n_samples_eff <= '0;
         loop          <= 1'b0;
         run_pulse     <= 1'b0;
         stop_pulse    <= 1'b0;
      end else begin
         rsp_valid_q <= req.valid;
         chan_rd_q   <= chan_rd;
         // Shot length clamped to buffer depth, frozen while busy
         if (nsamp_wr && !busy) begin
            if (req.wdata > NUM_SAMP)
               n_samples_eff <= 32'(NUM_SAMP);
            else
               n_samples_eff <= req.wdata;
         end
         // Loop bit also frozen while busy
         if (ctrl_wr && !busy)
            loop <= req.wdata[apg_pkg::CTRL_LOOP_BIT];
         // Run lands one cycle after loop so the shot sees the new setting
         run_pulse  <= ctrl_wr & req.wdata[apg_pkg::CTRL_RUN_BIT] & ~busy;
         stop_pulse <= ctrl_wr & req.wdata[apg_pkg::CTRL_STOP_BIT];
      end
   end

   always_ff @(posedge axi_clk) begin
      rdata_q <= rdata_d;
   end

   // Capture word comes straight from the buffer's output register
   always_comb begin
      chan_word = '0;
      chan_word[NUM_SIG-1:0] = pop_data;
      rsp.valid = rsp_valid_q;
      rsp.rdata = chan_rd_q ? chan_word : rdata_q;
   end

endmodule

// File: rtl/apg_top.sv
// Top level of the arbitrary pattern generator with capture
// Host register port on axi_clk, pattern pins on wave_clk
// NUM_SIG and NUM_SAMP are set here and passed to the submodules

`timescale 1ns/1ps

module apg_top #(
   parameter int NUM_SIG  = 14,
   parameter int NUM_SAMP = 128
) (
   input  logic               axi_clk,
   input  logic               axi_resetn,
   input  logic               wave_clk,
   input  apg_pkg::reg_req_t  req,
   output apg_pkg::reg_rsp_t  rsp,
   output logic [NUM_SIG-1:0] output_signals,
   input  logic [NUM_SIG-1:0] input_signals
);

   // Host side
   logic                   push;
   logic [NUM_SIG-1:0]     push_data;
   logic                   pop;
   logic [NUM_SIG-1:0]     pop_data;
   logic [31:0]            write_len;
   logic [31:0]            read_ptr;
   logic [31:0]            n_samples_eff;
   logic                   loop;
   logic                   run_pulse;
   logic                   stop_pulse;
   // Handshake
   logic                   busy;
   logic                   triggered;
   logic                   shot_done;
   logic                   wave_go;
   logic                   stop_req;
   logic                   engine_done;
   // Engine side
   logic [31:0]            rd_index;
   logic [NUM_SIG-1:0]     rd_word;
   logic                   cap_en;
   logic [31:0]            cap_index;
   logic [NUM_SIG-1:0]     cap_word;
   logic [31:0]            sample_count;
   apg_pkg::engine_state_e state;
   apg_pkg::apg_status_t   status;

   // State is read across domains, only meaningful when idle
   always_comb begin
      status.busy      = busy;
      status.triggered = triggered;
      status.state     = state;
   end

   apg_regs #(.NUM_SIG(NUM_SIG), .NUM_SAMP(NUM_SAMP)) i_regs (
      .axi_clk(axi_clk), .axi_resetn(axi_resetn), .req(req), .rsp(rsp),
      .busy(busy), .status(status), .push(push), .push_data(push_data),
      .pop(pop), .pop_data(pop_data), .write_len(write_len), .read_ptr(read_ptr),
      .sample_count(sample_count), .n_samples_eff(n_samples_eff), .loop(loop),
      .run_pulse(run_pulse), .stop_pulse(stop_pulse)
   );

   apg_pattern_mem #(.NUM_SIG(NUM_SIG), .NUM_SAMP(NUM_SAMP)) i_mem (
      .axi_clk(axi_clk), .axi_resetn(axi_resetn), .wave_clk(wave_clk),
      .push(push), .push_data(push_data), .pop(pop), .pop_data(pop_data),
      .write_len(write_len), .read_ptr(read_ptr), .shot_done(shot_done),
      .rd_index(rd_index), .rd_word(rd_word), .cap_en(cap_en),
      .cap_index(cap_index), .cap_word(cap_word)
   );

   apg_trigger_sync i_sync (
      .axi_clk(axi_clk), .axi_resetn(axi_resetn), .wave_clk(wave_clk),
      .run_pulse(run_pulse), .stop_pulse(stop_pulse), .engine_done(engine_done),
      .wave_go(wave_go), .stop_req(stop_req), .busy(busy),
      .triggered(triggered), .shot_done(shot_done)
   );

   apg_wave_engine #(.NUM_SIG(NUM_SIG), .NUM_SAMP(NUM_SAMP)) i_engine (
      .wave_clk(wave_clk), .axi_resetn(axi_resetn), .wave_go(wave_go),
      .stop_req(stop_req), .n_samples_eff(n_samples_eff), .loop(loop),
      .rd_index(rd_index), .rd_word(rd_word), .cap_en(cap_en),
      .cap_index(cap_index), .cap_word(cap_word), .input_signals(input_signals),
      .output_signals(output_signals), .state(state), .engine_done(engine_done),
      .sample_count(sample_count)
   );

endmodule

// File: rtl/apg_trigger_sync.sv
// Run/done handshake between axi_clk and wave_clk
// Run is latched into triggered and carried to the engine as wave_go
// Engine done comes back through two flops and ends the shot

`timescale 1ns/1ps

module apg_trigger_sync (
   input  logic axi_clk,
   input  logic axi_resetn,
   input  logic wave_clk,
   input  logic run_pulse,
   input  logic stop_pulse,
   input  logic engine_done,
   output logic wave_go,
   output logic stop_req,
   output logic busy,
   output logic triggered,
   output logic shot_done
);

   logic done_meta;
   logic done_sync;
   logic stop_lvl;
   logic go_meta;
   logic stop_meta;
   logic shot_end;

   // Shot is over once done is seen on the axi side
   assign shot_end = triggered & done_sync;
   // Busy stays up until the engine has dropped done as well
   assign busy     = triggered | done_sync;

   // axi_clk side
   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         done_meta <= 1'b0;
         done_sync <= 1'b0;
         triggered <= 1'b0;
         stop_lvl  <= 1'b0;
         shot_done <= 1'b0;
      end else begin
         done_meta <= engine_done;
         done_sync <= done_meta;
         // Run only accepted while fully idle
         if (shot_end)
            triggered <= 1'b0;
         else if (run_pulse && !busy)
            triggered <= 1'b1;
         // Stop request held for the rest of the shot
         if (shot_end)
            stop_lvl <= 1'b0;
         else if (stop_pulse && triggered)
            stop_lvl <= 1'b1;
         shot_done <= shot_end;
      end
   end

   // wave_clk side, two flops per level
   always_ff @(posedge wave_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         go_meta   <= 1'b0;
         wave_go   <= 1'b0;
         stop_meta <= 1'b0;
         stop_req  <= 1'b0;
      end else begin
         go_meta   <= triggered;
         wave_go   <= go_meta;
         stop_meta <= stop_lvl;
         stop_req  <= stop_meta;
      end
   end

endmodule

// File: rtl/apg_wave_engine.sv
// Pattern playback engine, wave_clk domain
// Plays n_samples_eff pattern words on output_signals and captures
// input_signals at the same index, looping until stop when loop is set
// Holds done until wave_go falls

`timescale 1ns/1ps

module apg_wave_engine #(
   parameter int NUM_SIG  = 14,
   parameter int NUM_SAMP = 128
) (
   input  logic                   wave_clk,
   input  logic                   axi_resetn,
   input  logic                   wave_go,
   input  logic                   stop_req,
   input  logic [31:0]            n_samples_eff,
   input  logic                   loop,
   output logic [31:0]            rd_index,
   input  logic [NUM_SIG-1:0]     rd_word,
   output logic                   cap_en,
   output logic [31:0]            cap_index,
   output logic [NUM_SIG-1:0]     cap_word,
   input  logic [NUM_SIG-1:0]     input_signals,
   output logic [NUM_SIG-1:0]     output_signals,
   output apg_pkg::engine_state_e state,
   output logic                   engine_done,
   output logic [31:0]            sample_count
);

   logic [31:0] wave_ptr;
   logic        last;

   // Last index of the shot, also bounded by the buffer depth
   assign last = (wave_ptr >= n_samples_eff - 32'd1) ||
                 (wave_ptr >= NUM_SAMP - 1);

   // Pattern fetch and capture share one index
   assign rd_index  = wave_ptr;
   assign cap_en    = (state == apg_pkg::TRANSACTION);
   assign cap_index = wave_ptr;
   assign cap_word  = input_signals;

   always_ff @(posedge wave_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         state          <= apg_pkg::IDLE;
         wave_ptr       <= '0;
         output_signals <= '0;
         engine_done    <= 1'b0;
         sample_count   <= '0;
      end else begin
         case (state)
            apg_pkg::IDLE: begin
               output_signals <= '0;
               wave_ptr       <= '0;
               if (wave_go) begin
                  // Empty shot goes straight to done
                  if (n_samples_eff == 32'd0) begin
                     state       <= apg_pkg::DONE;
                     engine_done <= 1'b1;
                  end else begin
                     state <= apg_pkg::TRANSACTION;
                  end
               end
            end
            apg_pkg::TRANSACTION: begin
               // Word shows on the pins one cycle after its index
               output_signals <= rd_word;
               sample_count   <= sample_count + 32'd1;
               if (last) begin
                  wave_ptr <= '0;
                  // Loop shots only stop on a whole repetition
                  if (!loop || stop_req) begin
                     state       <= apg_pkg::DONE;
                     engine_done <= 1'b1;
                  end
               end else begin
                  wave_ptr <= wave_ptr + 32'd1;
               end
            end
            apg_pkg::DONE: begin
               output_signals <= '0;
               wave_ptr       <= '0;
               // Wait for the axi side to acknowledge
               if (!wave_go) begin
                  state       <= apg_pkg::IDLE;
                  engine_done <= 1'b0;
               end
            end
            default: begin
               state          <= apg_pkg::IDLE;
               output_signals <= '0;
               engine_done    <= 1'b0;
            end
         endcase
      end
   end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the pattern generator testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module apg_tb -f build.f -o apg_sim \
   && ./obj_dir/apg_sim | tee sim.log \
   || echo "Build or simulation did not complete"
grep -qs "Done: no errors" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// File: verification/apg_checker.sv
// Checker for the pattern generator testbench
// Watches the host bus and the pattern pins beside the DUT
// The testbench top feeds expected values in through tasks and reads the error count

`timescale 1ns/1ps

module apg_checker #(
   parameter int NUM_SIG = 14
) (
   input logic               axi_clk,
   input logic               axi_resetn,
   input logic               wave_clk,
   input apg_pkg::reg_req_t  req,
   input apg_pkg::reg_rsp_t  rsp,
   input logic [NUM_SIG-1:0] output_signals
);

   int                 err_count  = 0;
   int                 bus_errs   = 0;
   int                 test_count = 0;
   int                 test_err0  = 0;
   string              test_name  = "";
   int                 runs       = 0;
   int                 runs_base  = 0;
   int                 play_base  = 0;
   logic               in_run     = 1'b0;
   logic               req_q;
   logic [NUM_SIG-1:0] exp_q[$];
   logic [NUM_SIG-1:0] got_q[$];

   // Every request gets its response exactly one axi_clk later
   always @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         req_q <= 1'b0;
      end else begin
         if (rsp.valid !== req_q) begin
            $display("** Error at %0t: rsp.valid expected %b got %b", $time, req_q, rsp.valid);
            bus_errs++;
         end
         req_q <= req.valid;
      end
   end

   // Collect non-zero samples, count separate runs of them
   always @(posedge wave_clk) begin
      if (output_signals != '0) begin
         if (!in_run)
            runs++;
         got_q.push_back(output_signals);
         in_run = 1'b1;
      end else begin
         in_run = 1'b0;
      end
   end

   function automatic int total_errors();
      return err_count + bus_errs;
   endfunction

   function automatic int played_count();
      return got_q.size() - play_base;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("** Error at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
         err_count++;
      end
   endtask

   task automatic report_fail(input string what);
      $display("Failure at %0t: %s", $time, what);
      err_count++;
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_err0 = total_errors();
   endtask

   task automatic end_test();
      int n;
      n = total_errors() - test_err0;
      test_count++;
      if (n == 0)
         $display("Test %s: ok", test_name);
      else
         $display("Test %s: %0d errors", test_name, n);
   endtask

   // Start of a new shot, earlier samples are kept but skipped
   task automatic clear_play();
      exp_q.delete();
      play_base = got_q.size();
      runs_base = runs;
   endtask

   task automatic add_expected(input logic [NUM_SIG-1:0] w);
      exp_q.push_back(w);
   endtask

   // One unbroken run, same length and same words as expected
   task automatic compare_play();
      int n;
      n = played_count();
      if (runs - runs_base != 1)
         report_fail($sformatf("output_signals showed %0d runs of samples, expected one",
                               runs - runs_base));
      check_value("played sample count", exp_q.size(), n);
      for (int i = 0; i < n && i < exp_q.size(); i++)
         check_value($sformatf("output_signals[%0d]", i), 32'(exp_q[i]),
                     32'(got_q[play_base + i]));
   endtask

   task automatic final_report();
      $display("Summary: %0d tests, %0d errors", test_count, total_errors());
   endtask

endmodule

// File: verification/apg_tb.sv
// Testbench top for the pattern generator
// Drives the host bus, loops the pins back inverted and runs six tests
// Comparing is done in apg_checker next to the DUT

`timescale 1ns/1ps

module apg_tb;

   localparam int NUM_SIG     = 14;
   localparam int NUM_SAMP    = 128;
   localparam int WAVE_PERIOD = 12;
   localparam int POLL_LIMIT  = 1000;
   // Played samples of all shots, the loop shot allowed eight passes
   localparam int WORST_SAMPLES = 20 + NUM_SAMP + 8 * 8 + 10;
   localparam int WATCHDOG_NS   = WORST_SAMPLES * WAVE_PERIOD + 20000;

   logic               axi_clk;
   logic               wave_clk;
   logic               axi_resetn;
   apg_pkg::reg_req_t  req;
   apg_pkg::reg_rsp_t  rsp;
   logic [NUM_SIG-1:0] output_signals;
   logic [NUM_SIG-1:0] input_signals = '0;
   logic [NUM_SIG-1:0] loop_q;
   integer             seed;
   logic [NUM_SIG-1:0] pat_q[$];
   int                 shot_len;
   logic               shot_loop;
   int                 exp_count;
   logic [31:0]        rd;

   apg_top #(.NUM_SIG(NUM_SIG), .NUM_SAMP(NUM_SAMP)) i_dut (
      .axi_clk(axi_clk), .axi_resetn(axi_resetn), .wave_clk(wave_clk), .req(req),
      .rsp(rsp), .output_signals(output_signals), .input_signals(input_signals)
   );

   apg_checker #(.NUM_SIG(NUM_SIG)) i_chk (
      .axi_clk(axi_clk), .axi_resetn(axi_resetn), .wave_clk(wave_clk), .req(req),
      .rsp(rsp), .output_signals(output_signals)
   );

   initial begin
      axi_clk = 1'b0;
      forever #4 axi_clk = ~axi_clk;
   end

   initial begin
      wave_clk = 1'b0;
      forever #(WAVE_PERIOD / 2) wave_clk = ~wave_clk;
   end

   // Loopback, pins come back inverted one wave_clk later
   always @(posedge wave_clk) begin
      loop_q = ~output_signals;
      #1 input_signals = loop_q;
   end

   // Expected pin word at play position idx, wraps at the shot length
   function automatic logic [NUM_SIG-1:0] ref_play(input int idx);
      return pat_q[idx % shot_len];
   endfunction

   // Capture lags the pins by two samples, idle pins read back all ones
   function automatic logic [NUM_SIG-1:0] ref_capture(input int idx);
      return (idx < 2) ? '1 : ~pat_q[idx - 2];
   endfunction

   function automatic int ref_clamp(input int n);
      return (n > NUM_SAMP) ? NUM_SAMP : n;
   endfunction

   // Called 1 ns after an edge, returns 1 ns after the response edge
   task automatic bus_access(input logic wr, input apg_pkg::reg_addr_e addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      req.valid = 1'b1;
      req.write = wr;
      req.addr  = addr;
      req.wdata = wdata;
      @(posedge axi_clk);
      #1;
      req.valid = 1'b0;
      req.write = 1'b0;
      rdata     = rsp.rdata;
   endtask

   task automatic write_reg(input apg_pkg::reg_addr_e addr, input logic [31:0] data);
      logic [31:0] unused;
      bus_access(1'b1, addr, data, unused);
   endtask

   task automatic expect_reg(input apg_pkg::reg_addr_e addr, input logic [31:0] exp);
      logic [31:0] rdata;
      bus_access(1'b0, addr, '0, rdata);
      i_chk.check_value(addr.name(), exp, rdata);
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge axi_clk);
      #1;
   endtask

   // Random non-zero words, the model keeps only what fits the buffer
   task automatic push_words(input int n, input logic keep);
      logic [31:0] r;
      for (int i = 0; i < n; i++) begin
         r = $random(seed);
         if (r[NUM_SIG-1:0] == '0)
            r[0] = 1'b1;
         write_reg(apg_pkg::WRITE_CHANNEL, r);
         if (keep && pat_q.size() < NUM_SAMP)
            pat_q.push_back(r[NUM_SIG-1:0]);
      end
   endtask

   task automatic start_shot(input int n_req, input logic loop_en);
      write_reg(apg_pkg::N_SAMPLES, 32'(n_req));
      shot_len  = ref_clamp(n_req);
      shot_loop = loop_en;
      i_chk.clear_play();
      write_reg(apg_pkg::CTRL, (32'(loop_en) << apg_pkg::CTRL_LOOP_BIT) |
                               (32'd1 << apg_pkg::CTRL_RUN_BIT));
      // Triggered is up two cycles after the CTRL write
      idle(2);
   endtask

   // Poll STATUS until busy drops, then compare the shot
   task automatic finish_shot();
      logic [31:0]          st;
      apg_pkg::apg_status_t stat;
      int                   polls;
      int                   reps;
      polls = 0;
      bus_access(1'b0, apg_pkg::STATUS, '0, st);
      stat = apg_pkg::apg_status_t'(st[3:0]);
      if (!stat.busy)
         i_chk.report_fail("STATUS busy did not rise after the run command");
      while (stat.busy && polls < POLL_LIMIT) begin
         bus_access(1'b0, apg_pkg::STATUS, '0, st);
         stat = apg_pkg::apg_status_t'(st[3:0]);
         polls++;
      end
      if (stat.busy)
         i_chk.report_fail("shot did not finish, STATUS busy stayed high");
      i_chk.check_value("STATUS.state", 32'(apg_pkg::IDLE), 32'(stat.state));
      // Loop shot ends on a whole repetition
      reps = 1;
      if (shot_loop)
         reps = (i_chk.played_count() + shot_len - 1) / shot_len;
      for (int i = 0; i < reps * shot_len; i++)
         i_chk.add_expected(ref_play(i));
      i_chk.compare_play();
      exp_count += reps * shot_len;
      expect_reg(apg_pkg::SAMPLE_COUNT, 32'(exp_count));
      expect_reg(apg_pkg::WRITE_LEN, 32'd0);
   endtask

   initial begin
      seed       = 75801;
      req        = '0;
      axi_resetn = 1'b0;
      exp_count  = 0;
      shot_len   = 1;
      shot_loop  = 1'b0;
      repeat (10) @(posedge axi_clk);
      #1;
      axi_resetn = 1'b1;
      idle(2);

      i_chk.begin_test("register access");
      write_reg(apg_pkg::N_SAMPLES, 32'(NUM_SAMP + 10));
      expect_reg(apg_pkg::N_SAMPLES, 32'(NUM_SAMP));
      write_reg(apg_pkg::N_SAMPLES, 32'd7);
      expect_reg(apg_pkg::N_SAMPLES, 32'd7);
      expect_reg(apg_pkg::SAMPLE_COUNT, 32'd0);
      i_chk.end_test();

      i_chk.begin_test("single shot");
      push_words(20, 1'b1);
      expect_reg(apg_pkg::WRITE_LEN, 32'(pat_q.size()));
      start_shot(20, 1'b0);
      finish_shot();
      i_chk.end_test();

      i_chk.begin_test("capture readback");
      for (int i = 0; i < 20; i++) begin
         bus_access(1'b0, apg_pkg::READ_CHANNEL, '0, rd);
         i_chk.check_value($sformatf("READ_CHANNEL[%0d]", i), 32'(ref_capture(i)), rd);
         expect_reg(apg_pkg::READ_PTR, 32'(i + 1));
      end
      i_chk.end_test();

      i_chk.begin_test("overflow");
      pat_q.delete();
      push_words(NUM_SAMP + 5, 1'b1);
      expect_reg(apg_pkg::WRITE_LEN, 32'(pat_q.size()));
      start_shot(NUM_SAMP, 1'b0);
      finish_shot();
      i_chk.end_test();

      i_chk.begin_test("loop and stop");
      pat_q.delete();
      push_words(8, 1'b1);
      start_shot(8, 1'b1);
      repeat (40) @(posedge wave_clk);
      idle(1);
      write_reg(apg_pkg::CTRL, (32'd1 << apg_pkg::CTRL_LOOP_BIT) |
                               (32'd1 << apg_pkg::CTRL_STOP_BIT));
      finish_shot();
      if (i_chk.played_count() < 2 * 8)
         i_chk.report_fail("loop shot did not repeat the pattern");
      i_chk.end_test();

      i_chk.begin_test("busy lockout");
      pat_q.delete();
      push_words(10, 1'b1);
      start_shot(10, 1'b0);
      // Ignored while the shot runs
      push_words(5, 1'b0);
      write_reg(apg_pkg::N_SAMPLES, 32'd50);
      expect_reg(apg_pkg::WRITE_LEN, 32'd10);
      expect_reg(apg_pkg::N_SAMPLES, 32'd10);
      finish_shot();
      expect_reg(apg_pkg::N_SAMPLES, 32'd10);
      i_chk.end_test();

      i_chk.final_report();
      if (i_chk.total_errors() == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout after %0d ns, the tests did not reach their end", WATCHDOG_NS);
      $display("Done: errors found");
      $finish;
   end

endmodule
